/* design/hwpe_regfile_pkg.sv */
// HWPE control register file package
// Register map, widths, response and status codes shared by the RTL

package hwpe_regfile_pkg;

  localparam int unsigned DATA_W    = 32;
  localparam int unsigned ADDR_W    = 8;
  localparam int unsigned STRB_W    = DATA_W / 8;
  localparam int unsigned N_CONTEXT = 2;
  localparam int unsigned CTX_W     = 1;
  localparam int unsigned N_IO_REGS = 4;
  localparam int unsigned IO_W      = 2;
  localparam int unsigned JOB_ID_W  = 8;
  localparam int unsigned FIN_W     = 2;
  localparam int unsigned CNT_W     = $clog2(N_CONTEXT + 1); // Busy context count

  // Register byte offsets
  localparam logic [ADDR_W-1:0] ADDR_ACQUIRE     = 8'h00;
  localparam logic [ADDR_W-1:0] ADDR_TRIGGER     = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_FINISHED    = 8'h08;
  localparam logic [ADDR_W-1:0] ADDR_STATUS      = 8'h0C;
  localparam logic [ADDR_W-1:0] ADDR_RUNNING_JOB = 8'h10;
  localparam logic [ADDR_W-1:0] ADDR_SOFTCLEAR   = 8'h14;
  localparam logic [ADDR_W-1:0] ADDR_IO_BASE     = 8'h40;
  localparam logic [ADDR_W-1:0] IO_CTX_STRIDE    = 8'h10;
  localparam logic [ADDR_W-1:0] IO_SPAN          = ADDR_W'(N_CONTEXT * IO_CTX_STRIDE);

  // Read responses
  localparam logic [DATA_W-1:0] RESP_OFFLOADING = 32'hFFFF_FFFE;
  localparam logic [DATA_W-1:0] RESP_ALL_BUSY   = 32'hFFFF_FFFF;
  localparam logic [DATA_W-1:0] RESP_UNMAPPED   = 32'hDEAD_BEEF;
  localparam logic [1:0]        AXI_RESP_OKAY   = 2'b00;

  localparam logic [FIN_W-1:0] FINISHED_MAX = 2'd2;
  localparam logic [7:0]       CTX_BUSY     = 8'h01; // Status byte of an occupied context

  typedef enum logic {
    IDLE,
    ACQUIRED
  } job_state_t;

endpackage

/* design/axil_reg_port.sv */
// AXI4-Lite slave port of the HWPE register file
// Decodes accepted transfers into one-cycle strobes and registers read data

`timescale 1ns/1ns

module axil_reg_port import hwpe_regfile_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [ADDR_W-1:0]   awaddr_i,
  input  logic                awvalid_i,
  output logic                awready_o,
  input  logic [DATA_W-1:0]   wdata_i,
  input  logic [STRB_W-1:0]   wstrb_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  output logic [1:0]          bresp_o,
  output logic                bvalid_o,
  input  logic                bready_i,
  input  logic [ADDR_W-1:0]   araddr_i,
  input  logic                arvalid_i,
  output logic                arready_o,
  output logic [DATA_W-1:0]   rdata_o,
  output logic [1:0]          rresp_o,
  output logic                rvalid_o,
  input  logic                rready_i,
  input  logic [DATA_W-1:0]   acq_resp_i,
  input  logic [DATA_W-1:0]   status_i,
  input  logic [FIN_W-1:0]    finished_i,
  input  logic [JOB_ID_W-1:0] running_id_i,
  input  logic [DATA_W-1:0]   io_rdata_i,
  output logic                acquire_o,
  output logic                trigger_o,
  output logic                fin_clear_o,
  output logic                soft_clear_o,
  output logic                io_we_o,
  output logic [CTX_W-1:0]    io_ctx_o,
  output logic [IO_W-1:0]     io_idx_o,
  output logic [CTX_W-1:0]    io_rd_ctx_o,
  output logic [IO_W-1:0]     io_rd_idx_o,
  output logic [DATA_W-1:0]   wdata_o,
  output logic [STRB_W-1:0]   wstrb_o
);

  logic              wready_q, bvalid_q;
  logic              arready_q, rvalid_q;
  logic [DATA_W-1:0] rdata_q, rd_mux;
  logic              wr_acc, rd_acc;
  logic [ADDR_W-1:0] aw_off, ar_off;
  logic              aw_io, ar_io;

  assign wr_acc = wready_q & awvalid_i & wvalid_i;
  assign rd_acc = arready_q & arvalid_i;

  // I/O window decode, word aligned only
  assign aw_off = awaddr_i - ADDR_IO_BASE;
  assign ar_off = araddr_i - ADDR_IO_BASE;
  assign aw_io  = (awaddr_i >= ADDR_IO_BASE) && (aw_off < IO_SPAN) && (awaddr_i[1:0] == 2'b00);
  assign ar_io  = (araddr_i >= ADDR_IO_BASE) && (ar_off < IO_SPAN) && (araddr_i[1:0] == 2'b00);

  assign io_ctx_o    = aw_off[IO_W+2 +: CTX_W];
  assign io_idx_o    = aw_off[2 +: IO_W];
  assign io_rd_ctx_o = ar_off[IO_W+2 +: CTX_W];
  assign io_rd_idx_o = ar_off[2 +: IO_W];

  assign acquire_o    = rd_acc & (araddr_i == ADDR_ACQUIRE);
  assign trigger_o    = wr_acc & (awaddr_i == ADDR_TRIGGER);
  assign fin_clear_o  = wr_acc & (awaddr_i == ADDR_FINISHED);
  assign soft_clear_o = wr_acc & (awaddr_i == ADDR_SOFTCLEAR);
  assign io_we_o      = wr_acc & aw_io;
  assign wdata_o      = wdata_i;
  assign wstrb_o      = wstrb_i;

  // Write channel, address and data accepted together
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wready_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      wready_q <= !wready_q && awvalid_i && wvalid_i && !bvalid_q;
      if (wr_acc) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Read channel
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= !arready_q && arvalid_i && !rvalid_q;
      if (rd_acc) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (araddr_i)
      ADDR_ACQUIRE:     rd_mux = acq_resp_i;
      ADDR_TRIGGER:     rd_mux = '0;
      ADDR_SOFTCLEAR:   rd_mux = '0;
      ADDR_FINISHED:    rd_mux = DATA_W'(finished_i);
      ADDR_STATUS:      rd_mux = status_i;
      ADDR_RUNNING_JOB: rd_mux = DATA_W'(running_id_i);
      default:          rd_mux = ar_io ? io_rdata_i : RESP_UNMAPPED;
    endcase
  end

  // Sampled from register values before the side effects of this access
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= rd_mux;
    end
  end

  assign awready_o = wready_q;
  assign wready_o  = wready_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = AXI_RESP_OKAY;
  assign arready_o = arready_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = AXI_RESP_OKAY; // Unmapped reads too

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_o && !bready_i |=> bvalid_o);
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

/* design/job_ctrl_fsm.sv */
// Offload state machine of the HWPE register file
// Tracks acquire/trigger, queues triggered contexts and schedules the engine

`timescale 1ns/1ns

module job_ctrl_fsm import hwpe_regfile_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                acquire_i,
  input  logic                trigger_i,
  input  logic                soft_clear_i,
  input  logic                done_i,
  input  logic [JOB_ID_W-1:0] offload_id_i,
  output logic [DATA_W-1:0]   acq_resp_o,
  output logic                offload_ok_o,
  output logic [DATA_W-1:0]   status_o,
  output logic                start_o,
  output logic [CTX_W-1:0]    run_ctx_o
);

  job_state_t           state_q;
  logic [CTX_W-1:0]     ptr_ctx_q;  // Next context to fill
  logic [CTX_W-1:0]     run_ctx_q;  // Oldest triggered context
  logic [N_CONTEXT-1:0] ctx_busy_q;
  logic [CNT_W-1:0]     busy_cnt_q;
  logic                 eng_busy_q;
  logic                 start_q;
  logic                 all_busy;
  logic                 trig_ok;
  logic                 launch;

  assign all_busy = (busy_cnt_q == CNT_W'(N_CONTEXT));
  assign trig_ok  = trigger_i && (state_q == ACQUIRED); // Trigger in IDLE is dropped
  assign launch   = !eng_busy_q && (busy_cnt_q != '0);

  // Test-and-set response
  always_comb begin
    offload_ok_o = 1'b0;
    if (state_q == ACQUIRED) begin
      acq_resp_o = RESP_OFFLOADING;
    end else if (all_busy) begin
      acq_resp_o = RESP_ALL_BUSY;
    end else begin
      acq_resp_o   = DATA_W'(offload_id_i);
      offload_ok_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ptr_ctx_q  <= '0;
      run_ctx_q  <= '0;
      ctx_busy_q <= '0;
      busy_cnt_q <= '0;
      eng_busy_q <= 1'b0;
      start_q    <= 1'b0;
    end else if (soft_clear_i) begin
      state_q    <= IDLE;
      ptr_ctx_q  <= '0;
      run_ctx_q  <= '0;
      ctx_busy_q <= '0;
      busy_cnt_q <= '0;
      eng_busy_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      if (acquire_i && offload_ok_o) begin
        state_q <= ACQUIRED;
      end else if (trig_ok) begin
        state_q <= IDLE;
      end
      if (trig_ok) begin
        ptr_ctx_q <= ptr_ctx_q + 1'b1; // Wraps, N_CONTEXT is a power of two
      end
      if (done_i) begin
        run_ctx_q <= run_ctx_q + 1'b1;
      end
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (trig_ok && (ptr_ctx_q == CTX_W'(c))) begin
          ctx_busy_q[c] <= 1'b1;
        end else if (done_i && (run_ctx_q == CTX_W'(c))) begin
          ctx_busy_q[c] <= 1'b0;
        end
      end
      busy_cnt_q <= busy_cnt_q + CNT_W'(trig_ok) - CNT_W'(done_i);
      start_q    <= launch;
      if (launch) begin
        eng_busy_q <= 1'b1;
      end else if (done_i) begin
        eng_busy_q <= 1'b0;
      end
    end
  end

  // One status byte per context, upper bytes read zero
  always_comb begin
    status_o = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      status_o[8*c +: 8] = ctx_busy_q[c] ? CTX_BUSY : 8'h00;
    end
  end

  assign start_o   = start_q;
  assign run_ctx_o = run_ctx_q;

  a_done_needs_engine: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> eng_busy_q);
  a_busy_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_cnt_q <= CNT_W'(N_CONTEXT));

endmodule

/* design/job_counters.sv */
// Job counters of the HWPE register file
// Offload id, running id and the saturating finished-job count

`timescale 1ns/1ns

module job_counters import hwpe_regfile_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                offload_ok_i,
  input  logic                acquire_i,
  input  logic                done_i,
  input  logic                fin_clear_i,
  input  logic                soft_clear_i,
  output logic [JOB_ID_W-1:0] offload_id_o,
  output logic [JOB_ID_W-1:0] running_id_o,
  output logic [FIN_W-1:0]    finished_o
);

  logic [JOB_ID_W-1:0] offload_id_q;
  logic [JOB_ID_W-1:0] running_id_q;
  logic [FIN_W-1:0]    finished_q;
  logic                done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      finished_q   <= '0;
      done_q       <= 1'b0;
    end else if (soft_clear_i) begin
      offload_id_q <= '0;
      running_id_q <= '0;
      finished_q   <= '0;
      done_q       <= 1'b0;
    end else begin
      done_q <= done_i;
      if (acquire_i && offload_ok_i) begin
        offload_id_q <= offload_id_q + 1'b1;
      end
      if (done_q) begin
        running_id_q <= running_id_q + 1'b1; // Lags done by one cycle
      end
      if (fin_clear_i) begin
        finished_q <= '0;
      end else if (done_i && (finished_q != FINISHED_MAX)) begin
        finished_q <= finished_q + 1'b1;
      end
    end
  end

  assign offload_id_o = offload_id_q;
  assign running_id_o = running_id_q;
  assign finished_o   = finished_q;

endmodule

/* design/io_param_bank.sv */
// Per-context I/O parameter registers
// Byte-enable writes from the bus and the running slice for the engine

`timescale 1ns/1ns

module io_param_bank import hwpe_regfile_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              soft_clear_i,
  input  logic                              we_i,
  input  logic [CTX_W-1:0]                  wr_ctx_i,
  input  logic [IO_W-1:0]                   wr_idx_i,
  input  logic [DATA_W-1:0]                 wdata_i,
  input  logic [STRB_W-1:0]                 wstrb_i,
  input  logic [CTX_W-1:0]                  rd_ctx_i,
  input  logic [IO_W-1:0]                   rd_idx_i,
  input  logic [CTX_W-1:0]                  run_ctx_i,
  output logic [DATA_W-1:0]                 rdata_o,
  output logic [N_IO_REGS-1:0][DATA_W-1:0]  params_o
);

  logic [N_CONTEXT-1:0][N_IO_REGS-1:0][DATA_W-1:0] mem_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (soft_clear_i) begin
      mem_q <= '0;
    end else if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[wr_ctx_i][wr_idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o  = mem_q[rd_ctx_i][rd_idx_i]; // Registered later in the bus port
  assign params_o = mem_q[run_ctx_i];

endmodule

/* design/hwpe_regfile_top.sv */
// HWPE control register file top level
// AXI4-Lite slave port, offload FSM, job counters and parameter bank

`timescale 1ns/1ns

module hwpe_regfile_top import hwpe_regfile_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [ADDR_W-1:0]                awaddr_i,
  input  logic                             awvalid_i,
  output logic                             awready_o,
  input  logic [DATA_W-1:0]                wdata_i,
  input  logic [STRB_W-1:0]                wstrb_i,
  input  logic                             wvalid_i,
  output logic                             wready_o,
  output logic [1:0]                       bresp_o,
  output logic                             bvalid_o,
  input  logic                             bready_i,
  input  logic [ADDR_W-1:0]                araddr_i,
  input  logic                             arvalid_i,
  output logic                             arready_o,
  output logic [DATA_W-1:0]                rdata_o,
  output logic [1:0]                       rresp_o,
  output logic                             rvalid_o,
  input  logic                             rready_i,
  output logic                             start_o,
  output logic [CTX_W-1:0]                 run_ctx_o,
  output logic [N_IO_REGS-1:0][DATA_W-1:0] params_o,
  input  logic                             done_i
);

  logic                acquire, trigger, fin_clear, soft_clear;
  logic                io_we;
  logic [CTX_W-1:0]    io_ctx, io_rd_ctx;
  logic [IO_W-1:0]     io_idx, io_rd_idx;
  logic [DATA_W-1:0]   wdata;
  logic [STRB_W-1:0]   wstrb;
  logic [DATA_W-1:0]   acq_resp, status, io_rdata;
  logic                offload_ok;
  logic [JOB_ID_W-1:0] offload_id, running_id;
  logic [FIN_W-1:0]    finished;

  axil_reg_port port_i (
    .clk_i, .rst_ni,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .acq_resp_i   (acq_resp),
    .status_i     (status),
    .finished_i   (finished),
    .running_id_i (running_id),
    .io_rdata_i   (io_rdata),
    .acquire_o    (acquire),
    .trigger_o    (trigger),
    .fin_clear_o  (fin_clear),
    .soft_clear_o (soft_clear),
    .io_we_o      (io_we),
    .io_ctx_o     (io_ctx),
    .io_idx_o     (io_idx),
    .io_rd_ctx_o  (io_rd_ctx),
    .io_rd_idx_o  (io_rd_idx),
    .wdata_o      (wdata),
    .wstrb_o      (wstrb)
  );

  job_ctrl_fsm fsm_i (
    .clk_i, .rst_ni,
    .acquire_i    (acquire),
    .trigger_i    (trigger),
    .soft_clear_i (soft_clear),
    .done_i,
    .offload_id_i (offload_id),
    .acq_resp_o   (acq_resp),
    .offload_ok_o (offload_ok),
    .status_o     (status),
    .start_o,
    .run_ctx_o
  );

  job_counters counters_i (
    .clk_i, .rst_ni,
    .offload_ok_i (offload_ok),
    .acquire_i    (acquire),
    .done_i,
    .fin_clear_i  (fin_clear),
    .soft_clear_i (soft_clear),
    .offload_id_o (offload_id),
    .running_id_o (running_id),
    .finished_o   (finished)
  );

  io_param_bank bank_i (
    .clk_i, .rst_ni,
    .soft_clear_i (soft_clear),
    .we_i         (io_we),
    .wr_ctx_i     (io_ctx),
    .wr_idx_i     (io_idx),
    .wdata_i      (wdata),
    .wstrb_i      (wstrb),
    .rd_ctx_i     (io_rd_ctx),
    .rd_idx_i     (io_rd_idx),
    .run_ctx_i    (run_ctx_o),
    .rdata_o      (io_rdata),
    .params_o
  );

endmodule

/* dv/regfile_checker.sv */
// Scoreboard for the HWPE register file testbench
// Compares read beats and engine starts with queued expected values

`timescale 1ns/1ns

module regfile_checker import hwpe_regfile_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             bvalid_i,
  input  logic                             bready_i,
  input  logic [1:0]                       bresp_i,
  input  logic                             rvalid_i,
  input  logic                             rready_i,
  input  logic [DATA_W-1:0]                rdata_i,
  input  logic [1:0]                       rresp_i,
  input  logic                             start_i,
  input  logic [CTX_W-1:0]                 run_ctx_i,
  input  logic [N_IO_REGS*DATA_W-1:0]      params_i
);

  logic [ADDR_W-1:0]           exp_addr_q[$];
  logic [DATA_W-1:0]           exp_data_q[$];
  logic [CTX_W-1:0]            seen_ctx_q[$];   // Starts not yet matched
  logic [N_IO_REGS*DATA_W-1:0] seen_params_q[$];
  logic [ADDR_W-1:0]           cur_addr;
  logic [DATA_W-1:0]           cur_data;
  int                          errors = 0;
  int                          checks = 0;
  int                          starts_seen = 0;

  task automatic expect_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic compare_start(input logic [CTX_W-1:0] ctx,
                               input logic [N_IO_REGS*DATA_W-1:0] params);
    logic [CTX_W-1:0]            got_ctx;
    logic [N_IO_REGS*DATA_W-1:0] got_params;
    if (seen_ctx_q.size() == 0) begin
      $display("Engine start for context %0d was expected but none was seen", ctx);
      errors++;
      return;
    end
    got_ctx    = seen_ctx_q.pop_front();
    got_params = seen_params_q.pop_front();
    checks++;
    if (got_ctx !== ctx) begin
      $display("Mismatch run_ctx_o: got 0x%0h expected 0x%0h", got_ctx, ctx);
      errors++;
    end
    for (int r = 0; r < N_IO_REGS; r++) begin
      if (got_params[DATA_W*r +: DATA_W] !== params[DATA_W*r +: DATA_W]) begin
        $display("Mismatch params_o[%0d]: got 0x%08h expected 0x%08h", r,
                 got_params[DATA_W*r +: DATA_W], params[DATA_W*r +: DATA_W]);
        errors++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && bvalid_i && bready_i) begin
      checks++;
      if (bresp_i !== AXI_RESP_OKAY) begin
        $display("Mismatch bresp_o: got 0x%0h expected 0x0", bresp_i);
        errors++;
      end
    end
    if (rst_ni && rvalid_i && rready_i) begin
      if (exp_data_q.size() == 0) begin
        $display("Read data returned while no read was expected");
        errors++;
      end else begin
        cur_addr = exp_addr_q.pop_front();
        cur_data = exp_data_q.pop_front();
        checks++;
        if (rdata_i !== cur_data) begin
          $display("Mismatch rdata_o at 0x%02h: got 0x%08h expected 0x%08h",
                   cur_addr, rdata_i, cur_data);
          errors++;
        end
        if (rresp_i !== AXI_RESP_OKAY) begin
          $display("Mismatch rresp_o at 0x%02h: got 0x%0h expected 0x0", cur_addr, rresp_i);
          errors++;
        end
      end
    end
    if (rst_ni && start_i) begin // Kept until the test data names the run
      seen_ctx_q.push_back(run_ctx_i);
      seen_params_q.push_back(params_i);
      starts_seen++;
    end
  end

endmodule

/* dv/tb_hwpe_regfile.sv */
// Testbench for the HWPE control register file
// Replays the test data over AXI4-Lite and models the processing engine

`timescale 1ns/1ns

module tb_hwpe_regfile import hwpe_regfile_pkg::*; ();

  localparam int TIMEOUT    = 200; // Cycles allowed per wait
  localparam int CLK_PERIOD = 20;
  localparam     DATA_FILE  = "dv/hwpe_regfile_testdata.txt";

  logic                             clk, rst_n;
  logic [ADDR_W-1:0]                awaddr, araddr;
  logic                             awvalid, awready, wvalid, wready;
  logic [DATA_W-1:0]                wdata, rdata;
  logic [STRB_W-1:0]                wstrb;
  logic [1:0]                       bresp, rresp;
  logic                             bvalid, bready;
  logic                             arvalid, arready, rvalid, rready;
  logic                             start, done;
  logic [CTX_W-1:0]                 run_ctx;
  logic [N_IO_REGS-1:0][DATA_W-1:0] params;
  logic                             aborted;
  int                               runs_done;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  hwpe_regfile_top dut_i (
    .clk_i (clk), .rst_ni (rst_n),
    .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .start_o (start), .run_ctx_o (run_ctx), .params_o (params), .done_i (done)
  );

  regfile_checker checker_i (
    .clk_i (clk), .rst_ni (rst_n),
    .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
    .rvalid_i (rvalid), .rready_i (rready), .rdata_i (rdata), .rresp_i (rresp),
    .start_i (start), .run_ctx_i (run_ctx), .params_i (params)
  );

  task automatic report_timeout(input string what);
    $display("Timeout: no %0s within %0d cycles", what, TIMEOUT);
    aborted = 1'b1;
  endtask

  task automatic next_cycle(); // Inputs change 2 ns after the edge
    @(posedge clk);
    #2;
  endtask

  task automatic stall_random();
    repeat ($urandom % 4) next_cycle();
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready) && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!(awready && wready)) begin
      report_timeout("write address/data handshake");
      return;
    end
    next_cycle(); // Accepted on this edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!bvalid) begin
      report_timeout("write response");
      return;
    end
    stall_random();
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
    int n;
    checker_i.expect_read(addr, expected);
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!arready) begin
      report_timeout("read address handshake");
      return;
    end
    next_cycle();
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!rvalid) begin
      report_timeout("read data");
      return;
    end
    stall_random();
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  // Engine model answering the oldest start after a random delay
  task automatic run_engine(input logic [CTX_W-1:0] ctx,
                            input logic [N_IO_REGS*DATA_W-1:0] exp_params);
    int n;
    n = 0;
    while (checker_i.starts_seen <= runs_done && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (checker_i.starts_seen <= runs_done) begin
      report_timeout("engine start");
      return;
    end
    checker_i.compare_start(ctx, exp_params);
    runs_done++;
    stall_random();
    done = 1'b1;
    next_cycle();
    done = 1'b0;
    repeat (2) next_cycle(); // Running id lags done by two cycles
  endtask

  initial begin
    int                fd;
    int                code;
    int                seed;
    int                tests_run;
    int                tests_failed;
    int                errs_at_start;
    logic              at_eof;
    logic [8*16-1:0]   op;
    logic [8*40-1:0]   name;
    logic [8*160-1:0]  line;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data, p0, p1, p2, p3;
    logic [STRB_W-1:0] strb;
    logic [CTX_W-1:0]  ctx;

    aborted       = 1'b0;
    runs_done     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    errs_at_start = 0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    done    = 1'b0;
    seed = $urandom(74);
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the test data file %0s", DATA_FILE);
      aborted = 1'b1;
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n  = 1'b1;
    at_eof = (fd == 0);

    while (!aborted && !at_eof) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        at_eof = 1'b1;
      end else begin
        case (op)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%h %h %h", addr, data, strb);
            write_reg(addr, data, strb);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", addr, data);
            read_reg(addr, data);
          end
          "E": begin
            code = $fscanf(fd, "%h %h %h %h %h", ctx, p0, p1, p2, p3);
            run_engine(ctx, {p3, p2, p1, p0});
          end
          "T": begin
            code = $fscanf(fd, "%s", name);
            tests_run++;
            if (checker_i.errors == errs_at_start) begin
              $display("Test %0s: PASS", name);
            end else begin
              tests_failed++;
              $display("Test %0s: FAIL with %0d errors", name, checker_i.errors - errs_at_start);
            end
            errs_at_start = checker_i.errors;
          end
          default: begin
            $display("Unknown operation %0s in the test data file", op);
            aborted = 1'b1;
          end
        endcase
      end
    end

    if (fd != 0) begin
      $fclose(fd);
    end
    if (checker_i.starts_seen != runs_done) begin
      $display("Engine started %0d jobs but the test data expected %0d",
               checker_i.starts_seen, runs_done);
    end
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checker_i.checks, checker_i.errors);
    if (!aborted && tests_run > 0 && tests_failed == 0 && checker_i.errors == 0 &&
        checker_i.starts_seen == runs_done) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* hwpe_regfile.f */
design/hwpe_regfile_pkg.sv
design/axil_reg_port.sv
design/job_ctrl_fsm.sv
design/job_counters.sv
design/io_param_bank.sv
design/hwpe_regfile_top.sv
dv/regfile_checker.sv
dv/tb_hwpe_regfile.sv

/* dv/hwpe_regfile_testdata.txt */
# W addr data strb | R addr expected | E ctx word0 word1 word2 word3
# T name closes a test, all numbers are hex
R 24 DEADBEEF
R 0C 00000000
R 08 00000000
R 10 00000000
T unmapped_and_reset
R 00 00000000
R 00 FFFFFFFE
W 40 11111111 F
W 04 00000000 F
R 00 00000001
T acquire_responses
W 50 AABBCCDD F
W 50 00001122 3
R 50 AABB1122
W 54 00000033 1
W 5C 44000000 8
R 5C 44000000
W 04 00000000 F
E 0 11111111 00000000 00000000 00000000
R 08 00000001
R 10 00000001
T params_to_engine
R 0C 00000100
R 00 00000002
W 40 22222222 F
W 4C 0000ABCD 3
W 04 00000000 F
R 0C 00000101
R 00 FFFFFFFF
T full_contexts
E 1 AABB1122 00000033 00000000 44000000
R 08 00000002
R 10 00000002
E 0 22222222 00000000 00000000 0000ABCD
R 08 00000002
R 10 00000003
W 08 00000000 F
R 08 00000000
R 0C 00000000
T completion_count
R 00 00000003
W 14 00000000 F
R 10 00000000
R 0C 00000000
R 40 00000000
R 50 00000000
R 00 00000000
T soft_clear
